// ==== design/vdec_buf_if.sv ====
`timescale 1ns/1ns

interface vdec_buf_if;

  logic                          wr_en;
  logic [vdec_pkg::buf_aw-1:0]   wr_addr;
  vdec_pkg::vdec_word_u          wr_data;
  logic [vdec_pkg::buf_aw-1:0]   rd_addr;
  vdec_pkg::vdec_word_u          rd_data;   // one cycle after rd_addr
  vdec_pkg::vdec_word_u          hdr_word;  // always word 0

  modport writer (output wr_en, output wr_addr, output wr_data);

  modport reader (output rd_addr, input rd_data);

  modport hdr (input hdr_word);

  modport store (input wr_en, input wr_addr, input wr_data, input rd_addr,
                 output rd_data, output hdr_word);

endinterface

// ==== design/vdec_cfg_regs.sv ====
`timescale 1ns/1ns

module vdec_cfg_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cfg_we,
  input  logic [1:0]                    cfg_addr,
  input  logic [31:0]                   cfg_wdata,
  input  logic                          frame_done,
  input  logic                          err_set,
  input  logic [1:0]                    err_code,
  output logic [31:0]                   cfg_rdata,
  output logic [vdec_pkg::addr_w-1:0]   frame_base,
  output logic [vdec_pkg::words_w-1:0]  frame_words
);

  logic [1:0] err_q;    // sticky until next good frame
  logic [7:0] frame_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_base  <= '0;
      frame_words <= vdec_pkg::words_w'(vdec_pkg::buf_depth);
      err_q       <= vdec_pkg::err_none;
      frame_cnt   <= '0;
    end else begin
      if (cfg_we && cfg_addr == vdec_pkg::cfg_addr_base) begin
        frame_base <= cfg_wdata[vdec_pkg::addr_w-1:0];
      end
      if (cfg_we && cfg_addr == vdec_pkg::cfg_addr_words) begin
        if (cfg_wdata > vdec_pkg::buf_depth) begin
          frame_words <= vdec_pkg::words_w'(vdec_pkg::buf_depth);  // clamp high
        end else if (cfg_wdata == '0) begin
          frame_words <= vdec_pkg::words_w'(1);
        end else begin
          frame_words <= cfg_wdata[vdec_pkg::words_w-1:0];
        end
      end
      if (err_set) begin
        err_q <= err_code;
      end else if (frame_done) begin
        err_q     <= vdec_pkg::err_none;
        frame_cnt <= frame_cnt + 8'd1;
      end
    end
  end

  always_comb begin
    case (cfg_addr)
      vdec_pkg::cfg_addr_base:   cfg_rdata = 32'(frame_base);
      vdec_pkg::cfg_addr_words:  cfg_rdata = 32'(frame_words);
      vdec_pkg::cfg_addr_status: cfg_rdata = {22'd0, err_q, frame_cnt};
      default:                   cfg_rdata = '0;
    endcase
  end

endmodule

// ==== design/vdec_fetch.sv ====
`timescale 1ns/1ns

module vdec_fetch (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic                          abort,
  input  logic [vdec_pkg::addr_w-1:0]   frame_base,
  input  logic [vdec_pkg::words_w-1:0]  frame_words,
  input  logic [31:0]                   mem_rdata,
  input  logic                          mem_ack,
  output logic                          mem_req,
  output logic [vdec_pkg::addr_w-1:0]   mem_addr,
  output logic                          done,
  vdec_buf_if.writer                    fbuf
);

  logic                         busy;
  logic [vdec_pkg::words_w-1:0] idx;  // words captured so far

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      mem_req <= 1'b0;
      idx     <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (abort) begin
        busy    <= 1'b0;  // any late ack just falls while idle
        mem_req <= 1'b0;
      end else if (start) begin
        busy <= 1'b1;
        idx  <= '0;
      end else if (busy) begin
        if (mem_req && mem_ack) begin
          mem_req <= 1'b0;  // word captured, release
          idx     <= idx + 1'b1;
        end else if (!mem_req && !mem_ack) begin
          if (idx == frame_words) begin
            busy <= 1'b0;
            done <= 1'b1;
          end else begin
            mem_req <= 1'b1;  // only once the previous ack is low
          end
        end
      end
    end
  end

  assign mem_addr = frame_base +
                    {{(vdec_pkg::addr_w - vdec_pkg::words_w){1'b0}}, idx};

  assign fbuf.wr_en   = busy && mem_req && mem_ack;
  assign fbuf.wr_addr = idx[vdec_pkg::buf_aw-1:0];
  assign fbuf.wr_data = mem_rdata;

endmodule

// ==== design/vdec_frame_buf.sv ====
`timescale 1ns/1ns

module vdec_frame_buf (
  input logic         clk,
  vdec_buf_if.store   fbuf
);

  vdec_pkg::vdec_word_u mem [vdec_pkg::buf_depth];

  always_ff @(posedge clk) begin
    if (fbuf.wr_en) begin
      mem[fbuf.wr_addr] <= fbuf.wr_data;
    end
    fbuf.rd_data <= mem[fbuf.rd_addr];  // registered read
  end

  // header tap for the parser
  assign fbuf.hdr_word = mem[0];

endmodule

// ==== design/vdec_parser.sv ====
`timescale 1ns/1ns

module vdec_parser (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic [vdec_pkg::words_w-1:0]  frame_words,
  output logic                          done,
  output logic                          err,
  output logic [1:0]                    err_code,
  output logic [15:0]                   ref_value,
  output logic [7:0]                    count,
  vdec_buf_if.hdr                       fbuf
);

  logic tag_bad;
  logic count_bad;

  assign tag_bad   = fbuf.hdr_word.hdr.tag != vdec_pkg::hdr_tag;
  // payload must fit in words 1 .. frame_words-1
  assign count_bad = fbuf.hdr_word.hdr.count == 8'd0 ||
                     fbuf.hdr_word.hdr.count >= 8'(frame_words);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done     <= 1'b0;
      err      <= 1'b0;
      err_code <= vdec_pkg::err_none;
    end else begin
      done <= start && !tag_bad && !count_bad;
      err  <= start && (tag_bad || count_bad);
      if (start) begin
        err_code <= tag_bad   ? vdec_pkg::err_tag :
                    count_bad ? vdec_pkg::err_count : vdec_pkg::err_none;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !tag_bad && !count_bad) begin
      ref_value <= fbuf.hdr_word.hdr.ref_value;
      count     <= fbuf.hdr_word.hdr.count;
    end
  end

endmodule

// ==== design/vdec_pkg.sv ====
package vdec_pkg;

  localparam int buf_depth = 16;  // words per frame buffer
  localparam int buf_aw    = 4;
  localparam int words_w   = 5;   // frame length register, 1 to 16
  localparam int addr_w    = 8;   // external memory word address

  localparam logic [7:0] hdr_tag = 8'ha5;

  localparam logic [1:0] err_none  = 2'd0;
  localparam logic [1:0] err_tag   = 2'd1;
  localparam logic [1:0] err_count = 2'd2;

  localparam logic [1:0] cfg_addr_base   = 2'd0;
  localparam logic [1:0] cfg_addr_words  = 2'd1;
  localparam logic [1:0] cfg_addr_status = 2'd2;

  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_parse,
    st_recon,
    st_error
  } seq_state_e;

  // word 0 is a header, words 1 and up carry residual pairs
  typedef union packed {
    struct packed {
      logic [7:0]  tag;
      logic [7:0]  count;
      logic [15:0] ref_value;
    } hdr;
    struct packed {
      logic signed [15:0] res_hi;
      logic signed [15:0] res_lo;
    } pay;
  } vdec_word_u;

endpackage

// ==== design/vdec_recon.sv ====
`timescale 1ns/1ns

module vdec_recon (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        abort,
  input  logic [15:0] ref_value,
  input  logic [7:0]  count,
  input  logic        out_ack,
  output logic        out_req,
  output logic [15:0] out_data,
  output logic        done,
  vdec_buf_if.reader  fbuf
);

  logic               busy;
  logic               rd_wait;  // buffer read in flight
  logic               sent;     // ack seen, waiting for it to fall
  logic               sel_lo;   // hi half first, then lo
  logic [7:0]         widx;
  logic signed [15:0] pred;
  logic signed [15:0] res;
  logic signed [16:0] sum;
  logic signed [15:0] sample;

  always_comb begin
    res = sel_lo ? fbuf.rd_data.pay.res_lo : fbuf.rd_data.pay.res_hi;
    sum = {pred[15], pred} + {res[15], res};
    if (sum[16:15] == 2'b01) begin
      sample = 16'sh7fff;  // positive overflow
    end else if (sum[16:15] == 2'b10) begin
      sample = 16'sh8000;
    end else begin
      sample = sum[15:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      rd_wait <= 1'b0;
      sent    <= 1'b0;
      sel_lo  <= 1'b0;
      out_req <= 1'b0;
      done    <= 1'b0;
      widx    <= '0;
    end else begin
      done <= 1'b0;
      if (abort) begin
        busy    <= 1'b0;  // a high ack still falls before any new request
        out_req <= 1'b0;
        sent    <= 1'b0;
      end else if (start) begin
        busy    <= 1'b1;
        widx    <= 8'd1;
        sel_lo  <= 1'b0;
        rd_wait <= 1'b1;
      end else if (busy) begin
        if (rd_wait) begin
          rd_wait <= 1'b0;
        end else if (out_req && out_ack) begin
          out_req <= 1'b0;
          sent    <= 1'b1;
        end else if (sent && !out_ack) begin
          sent <= 1'b0;
          if (!sel_lo) begin
            sel_lo <= 1'b1;  // same word, low residual
          end else if (widx == count) begin
            busy <= 1'b0;
            done <= 1'b1;
          end else begin
            widx    <= widx + 8'd1;
            sel_lo  <= 1'b0;
            rd_wait <= 1'b1;
          end
        end else if (!out_req && !sent && !out_ack) begin
          out_req <= 1'b1;
        end
      end
    end
  end

  // payload, loaded when a request is raised
  always_ff @(posedge clk) begin
    if (start) begin
      pred <= ref_value;
    end else if (busy && !abort && !rd_wait && !out_req && !sent && !out_ack) begin
      pred     <= sample;
      out_data <= sample;
    end
  end

  assign fbuf.rd_addr = widx[vdec_pkg::buf_aw-1:0];

endmodule

// ==== design/vdec_sequencer.sv ====
`timescale 1ns/1ns

module vdec_sequencer (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic       stall,
  input  logic       flush,
  input  logic       fetch_done,
  input  logic       parse_done,
  input  logic       parse_err,
  input  logic [1:0] parse_err_code,
  input  logic       recon_done,
  output logic       fetch_start,
  output logic       parse_start,
  output logic       recon_start,
  output logic       abort,
  output logic       done,
  output logic       err,
  output logic       err_set,
  output logic [1:0] err_code
);

  vdec_pkg::seq_state_e state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= vdec_pkg::st_idle;
      fetch_start <= 1'b0;
      parse_start <= 1'b0;
      recon_start <= 1'b0;
      abort       <= 1'b0;
      done        <= 1'b0;
      err_set     <= 1'b0;
      err_code    <= vdec_pkg::err_none;
    end else begin
      fetch_start <= 1'b0;  // all outputs are single pulses
      parse_start <= 1'b0;
      recon_start <= 1'b0;
      abort       <= 1'b0;
      done        <= 1'b0;
      err_set     <= 1'b0;
      if (flush && state != vdec_pkg::st_idle) begin
        // flush wins over any stage result in the same cycle
        abort <= 1'b1;
        state <= vdec_pkg::st_idle;
      end else begin
        case (state)
          vdec_pkg::st_idle: if (start && !stall) begin
            fetch_start <= 1'b1;
            state       <= vdec_pkg::st_fetch;
          end
          vdec_pkg::st_fetch: if (fetch_done) begin
            parse_start <= 1'b1;
            state       <= vdec_pkg::st_parse;
          end
          vdec_pkg::st_parse: if (parse_err) begin
            err_set  <= 1'b1;
            err_code <= parse_err_code;  // forwarded to status
            state    <= vdec_pkg::st_error;
          end else if (parse_done) begin
            recon_start <= 1'b1;
            state       <= vdec_pkg::st_recon;
          end
          vdec_pkg::st_recon: if (recon_done) begin
            done  <= 1'b1;
            state <= vdec_pkg::st_idle;
          end
          vdec_pkg::st_error: state <= vdec_pkg::st_error;  // only flush leaves
          default: state <= vdec_pkg::st_idle;
        endcase
      end
    end
  end

  assign err = (state == vdec_pkg::st_error);

endmodule

// ==== design/vdec_top.sv ====
`timescale 1ns/1ns

module vdec_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic                        stall,
  input  logic                        flush,
  output logic                        done,
  output logic                        err,
  output logic                        mem_req,
  output logic [vdec_pkg::addr_w-1:0] mem_addr,
  input  logic [31:0]                 mem_rdata,
  input  logic                        mem_ack,
  output logic                        out_req,
  output logic [15:0]                 out_data,
  input  logic                        out_ack,
  input  logic                        cfg_we,
  input  logic [1:0]                  cfg_addr,
  input  logic [31:0]                 cfg_wdata,
  output logic [31:0]                 cfg_rdata
);

  logic                         fetch_start, parse_start, recon_start, abort;
  logic                         fetch_done, parse_done, parse_err, recon_done;
  logic [1:0]                   parse_err_code;
  logic                         err_set;
  logic [1:0]                   err_code;
  logic [vdec_pkg::addr_w-1:0]  frame_base;
  logic [vdec_pkg::words_w-1:0] frame_words;
  logic [15:0]                  ref_value;
  logic [7:0]                   count;

  vdec_buf_if buf_if ();

  vdec_frame_buf u_buf (.clk(clk), .fbuf(buf_if.store));

  vdec_cfg_regs u_cfg (
    .clk(clk), .rst_n(rst_n), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .frame_done(done), .err_set(err_set),
    .err_code(err_code), .cfg_rdata(cfg_rdata), .frame_base(frame_base),
    .frame_words(frame_words));

  vdec_sequencer u_seq (
    .clk(clk), .rst_n(rst_n), .start(start), .stall(stall), .flush(flush),
    .fetch_done(fetch_done), .parse_done(parse_done), .parse_err(parse_err),
    .parse_err_code(parse_err_code), .recon_done(recon_done),
    .fetch_start(fetch_start), .parse_start(parse_start),
    .recon_start(recon_start), .abort(abort), .done(done), .err(err),
    .err_set(err_set), .err_code(err_code));

  vdec_fetch u_fetch (
    .clk(clk), .rst_n(rst_n), .start(fetch_start), .abort(abort),
    .frame_base(frame_base), .frame_words(frame_words), .mem_rdata(mem_rdata),
    .mem_ack(mem_ack), .mem_req(mem_req), .mem_addr(mem_addr),
    .done(fetch_done), .fbuf(buf_if.writer));

  vdec_parser u_parse (
    .clk(clk), .rst_n(rst_n), .start(parse_start), .frame_words(frame_words),
    .done(parse_done), .err(parse_err), .err_code(parse_err_code),
    .ref_value(ref_value), .count(count), .fbuf(buf_if.hdr));

  vdec_recon u_recon (
    .clk(clk), .rst_n(rst_n), .start(recon_start), .abort(abort),
    .ref_value(ref_value), .count(count), .out_ack(out_ack),
    .out_req(out_req), .out_data(out_data), .done(recon_done),
    .fbuf(buf_if.reader));

endmodule

// ==== dv/vdec_checker.sv ====
`timescale 1ns/1ns

module vdec_checker (
  input logic        clk,
  input logic        rst_n,
  input logic        abort,
  input logic        mem_req,
  input logic        mem_ack,
  input logic        out_req,
  input logic        out_ack,
  input logic [15:0] out_data,
  input logic        done,
  input logic        err
);

  // only an abort may withdraw a pending memory request
  mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && !mem_ack && !abort |=> mem_req)
    else $error("mem_req dropped before mem_ack");

  out_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_req |=> !out_req || $stable(out_data))
    else $error("out_data changed while out_req was high");

  done_err_apart: assert property (@(posedge clk) disable iff (!rst_n)
    !(done && err))
    else $error("done and err high in the same cycle");

  mem_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    !mem_req && mem_ack |=> !mem_req)
    else $error("mem_req raised while mem_ack was still high");

  out_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    !out_req && out_ack |=> !out_req)
    else $error("out_req raised while out_ack was still high");

endmodule

// ==== dv/vdec_tb.sv ====
`timescale 1ns/1ns

module vdec_tb;

  localparam int hs_worst      = 8;        // cycles for one slowest handshake
  localparam int frame_hs      = 16 + 30;  // fetches plus samples of a full frame
  localparam int n_frames      = 8;        // frames started over all tests
  localparam int timeout_limit = 4 * n_frames * frame_hs * hs_worst;

  logic        clk = 1'b0;
  logic        rst_n, start, stall, flush, done, err;
  logic        mem_req, out_req, cfg_we;
  logic        mem_ack = 1'b0;
  logic        out_ack = 1'b0;
  logic [7:0]  mem_addr;
  logic [31:0] mem_rdata = '0;
  logic [15:0] out_data;
  logic [1:0]  cfg_addr;
  logic [31:0] cfg_wdata, cfg_rdata;

  logic [31:0] mem [256];
  logic [15:0] exp_q [$];
  logic [15:0] data_lfsr = 16'd23;
  logic [15:0] delay_lfsr = 16'd23;
  int          cycles = 0, n_seen = 0, done_cnt = 0, frames_done = 0;
  int          mem_wait = 0, out_wait = 0;
  logic        mem_armed = 1'b0, out_armed = 1'b0;

  vdec_top dut (.*);

  bind vdec_top vdec_checker chk (.clk(clk), .rst_n(rst_n), .abort(abort),
    .mem_req(mem_req), .mem_ack(mem_ack), .out_req(out_req), .out_ack(out_ack),
    .out_data(out_data), .done(done), .err(err));

  always #2 clk = ~clk;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp == got) else fail_run($sformatf("error %s exp %h got %h", name, exp, got));
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_data(input int n, output logic [15:0] v);
    v = '0;
    repeat (n) begin
      data_lfsr = lfsr_step(data_lfsr);
      v = {v[14:0], data_lfsr[0]};
    end
  endtask

  task automatic draw_delay(output int d);
    d = 0;
    repeat (2) begin
      delay_lfsr = lfsr_step(delay_lfsr);
      d = d * 2 + int'(delay_lfsr[0]);
    end
  endtask

  // expected samples of the frame at base go onto exp_q
  function automatic int build_expected(input logic [7:0] base);
    logic [31:0]        w;
    logic signed [15:0] r;
    int                 pred, s, i, k;
    w    = mem[base];
    pred = int'($signed(w[15:0]));
    for (i = 1; i <= int'(w[23:16]); i++) begin
      for (k = 0; k < 2; k++) begin
        r = (k == 0) ? mem[base + 8'(i)][31:16] : mem[base + 8'(i)][15:0];
        s = pred + int'(r);
        if (s > 32767) s = 32767;
        else if (s < -32768) s = -32768;
        exp_q.push_back(16'(s));
        pred = s;
      end
    end
    return 2 * int'(w[23:16]);
  endfunction

  // memory and sample sink ack after 0 to 3 cycles
  always @(negedge clk) begin
    int d;
    if (mem_ack) begin
      if (!mem_req) mem_ack <= 1'b0;
    end else if (mem_req) begin
      if (!mem_armed) begin
        draw_delay(d);
        mem_wait  = d;
        mem_armed = 1'b1;
      end
      if (mem_wait == 0) begin
        mem_ack   <= 1'b1;
        mem_rdata <= mem[mem_addr];
        mem_armed = 1'b0;
      end else mem_wait--;
    end else mem_armed = 1'b0;
    if (out_ack) begin
      if (!out_req) out_ack <= 1'b0;
    end else if (out_req) begin
      if (!out_armed) begin
        draw_delay(d);
        out_wait  = d;
        out_armed = 1'b1;
      end
      if (out_wait == 0) begin
        out_ack   <= 1'b1;
        out_armed = 1'b0;
      end else out_wait--;
    end else out_armed = 1'b0;
  end

  always @(posedge clk) begin
    logic [15:0] want;
    if (rst_n && out_req && out_ack) begin
      if (exp_q.size() == 0) begin
        fail_run("out_data accepted while no sample was expected");
      end else begin
        want = exp_q.pop_front();
        assert (out_data == want)
          else fail_run($sformatf("error out_data exp %h got %h", want, out_data));
        n_seen++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (done) done_cnt++;
    if (cycles > timeout_limit)
      fail_run($sformatf("timeout, the run did not end within %0d cycles", timeout_limit));
  end

  task automatic set_cfg(input logic [1:0] addr, input logic [31:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic read_cfg(input logic [1:0] addr, output logic [31:0] data);
    cfg_addr = addr;
    #1;
    data = cfg_rdata;  // combinational read
    @(negedge clk);
  endtask

  task automatic write_frame(input logic [7:0] base, input logic [7:0] tag,
                             input logic [7:0] cnt);
    logic [15:0] refv, hi, lo;
    int          i;
    draw_data(16, refv);
    mem[base] = {tag, cnt, refv};
    for (i = 1; i < 16; i++) begin
      draw_data(12, hi);
      draw_data(12, lo);
      mem[base + 8'(i)] = {{4{hi[11]}}, hi[11:0], {4{lo[11]}}, lo[11:0]};
    end
  endtask

  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    @(negedge clk);
  endtask

  task automatic decode_frame(input logic [7:0] base);
    int          n_exp, seen0, done0;
    logic [31:0] st;
    set_cfg(vdec_pkg::cfg_addr_base, 32'(base));
    n_exp = build_expected(base);
    seen0 = n_seen;
    done0 = done_cnt;
    pulse_start();
    while (!done && !err) @(negedge clk);
    assert (!err) else fail_run("a valid frame ended in the error state");
    repeat (3) @(negedge clk);
    check_eq("sample_count", n_exp, n_seen - seen0);
    check_eq("done_pulses", 1, done_cnt - done0);
    frames_done++;
    read_cfg(vdec_pkg::cfg_addr_status, st);
    check_eq("cfg_rdata", {22'd0, vdec_pkg::err_none, 8'(frames_done)}, st);
  endtask

  task automatic expect_error(input logic [7:0] base, input logic [1:0] code);
    int          seen0;
    logic [31:0] st;
    set_cfg(vdec_pkg::cfg_addr_base, 32'(base));
    seen0 = n_seen;
    pulse_start();
    while (!done && !err) @(negedge clk);
    assert (err) else fail_run("a frame with a bad header finished without err");
    repeat (5) @(negedge clk);
    assert (err) else fail_run("err dropped before flush");
    check_eq("out_samples", 0, n_seen - seen0);
    read_cfg(vdec_pkg::cfg_addr_status, st);
    check_eq("cfg_rdata", {22'd0, code, 8'(frames_done)}, st);
    pulse_flush();
    assert (!err) else fail_run("err still high after flush");
  endtask

  task automatic flush_in_recon(input logic [7:0] base);
    int seen0;
    set_cfg(vdec_pkg::cfg_addr_base, 32'(base));
    void'(build_expected(base));
    seen0 = n_seen;
    pulse_start();
    while (n_seen - seen0 < 6) @(negedge clk);
    pulse_flush();  // abort has reached recon by now
    exp_q.delete();
    seen0 = n_seen;
    repeat (20) @(negedge clk);
    check_eq("out_samples", 0, n_seen - seen0);
  endtask

  initial begin
    logic [31:0] rd;
    int          a;
    rst_n     = 1'b0;
    start     = 1'b0;
    stall     = 1'b0;
    flush     = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    for (a = 0; a < 256; a++) mem[a] = {8'(a), ~8'(a), 8'(a) ^ 8'h96, 8'(a * 7)};
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    write_frame(8'h10, vdec_pkg::hdr_tag, 8'd15);
    decode_frame(8'h10);

    // saturation at both ends
    set_cfg(vdec_pkg::cfg_addr_words, 32'd8);
    write_frame(8'h40, vdec_pkg::hdr_tag, 8'd4);
    mem[8'h40] = {vdec_pkg::hdr_tag, 8'd4, 16'h7f00};
    mem[8'h41] = {16'h4000, 16'h7fff};
    mem[8'h42] = {16'h8000, 16'h8000};
    mem[8'h43] = {16'hf000, 16'h7fff};
    mem[8'h44] = {16'h8001, 16'h8001};
    decode_frame(8'h40);

    write_frame(8'h60, 8'h5a, 8'd3);
    expect_error(8'h60, vdec_pkg::err_tag);
    decode_frame(8'h40);

    write_frame(8'h60, vdec_pkg::hdr_tag, 8'd8);  // one word past the payload
    expect_error(8'h60, vdec_pkg::err_count);
    set_cfg(vdec_pkg::cfg_addr_words, 32'd20);
    read_cfg(vdec_pkg::cfg_addr_words, rd);
    check_eq("cfg_rdata", 32'd16, rd);

    write_frame(8'h80, vdec_pkg::hdr_tag, 8'd15);
    flush_in_recon(8'h80);
    decode_frame(8'h80);

    stall = 1'b1;
    pulse_start();
    repeat (20) begin
      assert (!mem_req) else fail_run("mem_req raised while stall was high");
      @(negedge clk);
    end
    stall = 1'b0;
    decode_frame(8'h10);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f sim.f --top-module vdec_tb -o vdec_sim &&
  ./obj_dir/vdec_sim | tee /dev/stderr | grep -q "^ALL CHECKS PASSED$" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// ==== sim.f ====
design/vdec_pkg.sv
design/vdec_buf_if.sv
design/vdec_frame_buf.sv
design/vdec_cfg_regs.sv
design/vdec_sequencer.sv
design/vdec_fetch.sv
design/vdec_parser.sv
design/vdec_recon.sv
design/vdec_top.sv
dv/vdec_checker.sv
dv/vdec_tb.sv
